// File: design/u2_ctrl_pkg.sv
// Control core shared definitions
package u2_ctrl_pkg;

   // Settings bus, time and readback types
   typedef logic [7:0]  set_addr_t;
   typedef logic [31:0] set_data_t;
   typedef logic [63:0] vita_time_t;
   typedef logic [3:0]  rb_addr_t;

   localparam int GPIO_WIDTH      = 32;
   localparam int PPS_SYNC_STAGES = 2;

   typedef logic [GPIO_WIDTH-1:0] gpio_t;
   typedef logic [7:0]            led_t;

   //////////////////////////////////////////////////
   // Settings register map

   localparam set_addr_t SR_MISC   = 8'd0;
   localparam set_addr_t SR_TIME64 = 8'd10;
   localparam set_addr_t SR_GPIO   = 8'd184;

   // Misc block
   localparam set_addr_t SR_CLK_CTRL = SR_MISC + 8'd0;
   localparam set_addr_t SR_SER_CTRL = SR_MISC + 8'd1;
   localparam set_addr_t SR_ADC_CTRL = SR_MISC + 8'd2;
   localparam set_addr_t SR_LED_SW   = SR_MISC + 8'd3;
   localparam set_addr_t SR_PHY_RST  = SR_MISC + 8'd4;
   localparam set_addr_t SR_LED_SRC  = SR_MISC + 8'd6;

   // Time block, a write to the low word commits the load
   localparam set_addr_t SR_TIME_HI   = SR_TIME64 + 8'd0;
   localparam set_addr_t SR_TIME_LO   = SR_TIME64 + 8'd1;
   localparam set_addr_t SR_TIME_MODE = SR_TIME64 + 8'd2;

   // GPIO ATR block
   localparam set_addr_t SR_GPIO_IDLE = SR_GPIO + 8'd0;
   localparam set_addr_t SR_GPIO_RX   = SR_GPIO + 8'd1;
   localparam set_addr_t SR_GPIO_TX   = SR_GPIO + 8'd2;
   localparam set_addr_t SR_GPIO_FDX  = SR_GPIO + 8'd3;
   localparam set_addr_t SR_GPIO_DDR  = SR_GPIO + 8'd4;

   //////////////////////////////////////////////////
   // Reset patterns and identification

   // LEDs 1 to 4 start under hardware control
   localparam led_t LED_SRC_RESET = 8'b0001_1110;

   // Major in the upper half, minor in the lower half
   localparam set_data_t COMPAT_NUM = {16'd8, 16'd3};

   //////////////////////////////////////////////////
   // Readback word indices

   localparam rb_addr_t RB_GPIO    = 4'd9;
   localparam rb_addr_t RB_TIME_HI = 4'd10;
   localparam rb_addr_t RB_TIME_LO = 4'd11;
   localparam rb_addr_t RB_COMPAT  = 4'd12;
   localparam rb_addr_t RB_STATUS  = 4'd13;
   localparam rb_addr_t RB_PPS_HI  = 4'd14;
   localparam rb_addr_t RB_PPS_LO  = 4'd15;

endpackage

// File: design/setting_reg.sv
// Addressed settings register
`timescale 1ns/1ps

module setting_reg #(
   parameter type                    payload_t = logic [31:0],
   parameter u2_ctrl_pkg::set_addr_t MY_ADDR   = 8'd0,
   parameter payload_t               AT_RESET  = '0
) (
   input  logic                   dsp_clk,
   input  logic                   arst_n_i,
   input  logic                   set_stb_i,
   input  u2_ctrl_pkg::set_addr_t set_addr_i,
   input  u2_ctrl_pkg::set_data_t set_data_i,
   output payload_t               value_o
);

   // Payload width, taken from the low end of the data word
   localparam int PW = $bits(payload_t);

   logic hit;

   assign hit = set_stb_i && (set_addr_i == MY_ADDR);

   always_ff @(posedge dsp_clk or negedge arst_n_i) begin
      if (!arst_n_i) begin
         value_o <= AT_RESET;
      end else if (hit) begin
         value_o <= payload_t'(set_data_i[PW-1:0]);
      end
   end

endmodule

// File: design/led_select.sv
// LED source selection
`timescale 1ns/1ps

module led_select (
   input  logic                   dsp_clk,
   input  logic                   arst_n_i,
   input  logic                   set_stb_i,
   input  u2_ctrl_pkg::set_addr_t set_addr_i,
   input  u2_ctrl_pkg::set_data_t set_data_i,
   input  logic                   rx_active_i,
   input  logic                   run_tx_i,
   input  logic                   clk_status_i,
   input  logic                   serdes_link_up_i,
   input  logic                   good_sync_i,
   output logic [7:0]             leds_o
);

   import u2_ctrl_pkg::*;

   led_t led_sw;
   led_t led_src;
   led_t led_hw;

   // Software pattern
   setting_reg #(
      .payload_t (led_t),
      .MY_ADDR   (SR_LED_SW),
      .AT_RESET  (8'h00)
   ) sr_led_sw (
      .dsp_clk    (dsp_clk),    .arst_n_i   (arst_n_i),
      .set_stb_i  (set_stb_i),  .set_addr_i (set_addr_i),
      .set_data_i (set_data_i), .value_o    (led_sw)
   );

   // Per-bit source, 1 picks hardware
   setting_reg #(
      .payload_t (led_t),
      .MY_ADDR   (SR_LED_SRC),
      .AT_RESET  (LED_SRC_RESET)
   ) sr_led_src (
      .dsp_clk    (dsp_clk),    .arst_n_i   (arst_n_i),
      .set_stb_i  (set_stb_i),  .set_addr_i (set_addr_i),
      .set_data_i (set_data_i), .value_o    (led_src)
   );

   // Hardware status, LED 1 lights only once time is synced with the link up
   assign led_hw = {3'b000, run_tx_i, rx_active_i, clk_status_i,
                    serdes_link_up_i & good_sync_i, 1'b0};

   assign leds_o = (led_src & led_hw) | (~led_src & led_sw);

endmodule

// File: design/gpio_atr.sv
// GPIO automatic transmit/receive
`timescale 1ns/1ps

module gpio_atr (
   input  logic                               dsp_clk,
   input  logic                               arst_n_i,
   input  logic                               set_stb_i,
   input  u2_ctrl_pkg::set_addr_t             set_addr_i,
   input  u2_ctrl_pkg::set_data_t             set_data_i,
   input  logic                               rx_active_i,
   input  logic                               run_tx_i,
   output logic [u2_ctrl_pkg::GPIO_WIDTH-1:0] gpio_o,
   output logic [u2_ctrl_pkg::GPIO_WIDTH-1:0] gpio_oe_o
);

   import u2_ctrl_pkg::*;

   gpio_t atr_idle;
   gpio_t atr_rx;
   gpio_t atr_tx;
   gpio_t atr_fdx;

   //////////////////////////////////////////////////
   // Per-state output values

   setting_reg #(.payload_t(gpio_t), .MY_ADDR(SR_GPIO_IDLE), .AT_RESET('0)) sr_idle (
      .dsp_clk    (dsp_clk),    .arst_n_i   (arst_n_i),
      .set_stb_i  (set_stb_i),  .set_addr_i (set_addr_i),
      .set_data_i (set_data_i), .value_o    (atr_idle)
   );

   setting_reg #(.payload_t(gpio_t), .MY_ADDR(SR_GPIO_RX), .AT_RESET('0)) sr_rx (
      .dsp_clk    (dsp_clk),    .arst_n_i   (arst_n_i),
      .set_stb_i  (set_stb_i),  .set_addr_i (set_addr_i),
      .set_data_i (set_data_i), .value_o    (atr_rx)
   );

   setting_reg #(.payload_t(gpio_t), .MY_ADDR(SR_GPIO_TX), .AT_RESET('0)) sr_tx (
      .dsp_clk    (dsp_clk),    .arst_n_i   (arst_n_i),
      .set_stb_i  (set_stb_i),  .set_addr_i (set_addr_i),
      .set_data_i (set_data_i), .value_o    (atr_tx)
   );

   setting_reg #(.payload_t(gpio_t), .MY_ADDR(SR_GPIO_FDX), .AT_RESET('0)) sr_fdx (
      .dsp_clk    (dsp_clk),    .arst_n_i   (arst_n_i),
      .set_stb_i  (set_stb_i),  .set_addr_i (set_addr_i),
      .set_data_i (set_data_i), .value_o    (atr_fdx)
   );

   // Direction, 1 drives the pin
   setting_reg #(.payload_t(gpio_t), .MY_ADDR(SR_GPIO_DDR), .AT_RESET('0)) sr_ddr (
      .dsp_clk    (dsp_clk),    .arst_n_i   (arst_n_i),
      .set_stb_i  (set_stb_i),  .set_addr_i (set_addr_i),
      .set_data_i (set_data_i), .value_o    (gpio_oe_o)
   );

   //////////////////////////////////////////////////
   // State-driven output register

   always_ff @(posedge dsp_clk or negedge arst_n_i) begin
      if (!arst_n_i) begin
         gpio_o <= '0;
      end else begin
         case ({rx_active_i, run_tx_i})
            2'b00:   gpio_o <= atr_idle;
            2'b01:   gpio_o <= atr_tx;
            2'b10:   gpio_o <= atr_rx;
            default: gpio_o <= atr_fdx;
         endcase
      end
   end

endmodule

// File: design/vita_time.sv
// VITA time counter with PPS sync
`timescale 1ns/1ps

module vita_time (
   input  logic                    dsp_clk,
   input  logic                    arst_n_i,
   input  logic                    set_stb_i,
   input  u2_ctrl_pkg::set_addr_t  set_addr_i,
   input  u2_ctrl_pkg::set_data_t  set_data_i,
   input  logic                    pps_i,
   output u2_ctrl_pkg::vita_time_t vita_time_o,
   output u2_ctrl_pkg::vita_time_t vita_time_pps_o,
   output logic                    good_sync_o
);

   import u2_ctrl_pkg::*;

   set_data_t  time_hi;
   logic       load_now;
   set_data_t  pending_lo;
   logic       commit_stb;
   logic       imm_load;
   logic       pps_load;
   logic       armed;
   logic [PPS_SYNC_STAGES:0] pps_sh;
   logic       pps_edge;
   vita_time_t time_next;

   //////////////////////////////////////////////////
   // Load registers

   setting_reg #(.payload_t(set_data_t), .MY_ADDR(SR_TIME_HI), .AT_RESET('0)) sr_time_hi (
      .dsp_clk    (dsp_clk),    .arst_n_i   (arst_n_i),
      .set_stb_i  (set_stb_i),  .set_addr_i (set_addr_i),
      .set_data_i (set_data_i), .value_o    (time_hi)
   );

   // Bit 0 set loads on commit, clear waits for PPS
   setting_reg #(.payload_t(logic), .MY_ADDR(SR_TIME_MODE), .AT_RESET(1'b0)) sr_time_mode (
      .dsp_clk    (dsp_clk),    .arst_n_i   (arst_n_i),
      .set_stb_i  (set_stb_i),  .set_addr_i (set_addr_i),
      .set_data_i (set_data_i), .value_o    (load_now)
   );

   assign commit_stb = set_stb_i && (set_addr_i == SR_TIME_LO);
   assign imm_load   = commit_stb && load_now;
   assign pps_load   = armed && pps_edge;

   // Low word held for an armed load
   always_ff @(posedge dsp_clk) begin
      if (commit_stb) begin
         pending_lo <= set_data_i;
      end
   end

   always_ff @(posedge dsp_clk or negedge arst_n_i) begin
      if (!arst_n_i) begin
         armed <= 1'b0;
      end else if (commit_stb) begin
         armed <= !load_now;
      end else if (pps_load) begin
         armed <= 1'b0;
      end
   end

   //////////////////////////////////////////////////
   // PPS synchronizer and rising edge

   // Top bit is one cycle behind the synchronizer output
   always_ff @(posedge dsp_clk or negedge arst_n_i) begin
      if (!arst_n_i) begin
         pps_sh <= '0;
      end else begin
         pps_sh <= {pps_sh[PPS_SYNC_STAGES-1:0], pps_i};
      end
   end

   assign pps_edge = pps_sh[PPS_SYNC_STAGES-1] & ~pps_sh[PPS_SYNC_STAGES];

   //////////////////////////////////////////////////
   // Counter, PPS latch and sync flag

   always_comb begin
      if (imm_load) begin
         time_next = {time_hi, set_data_i};
      end else if (pps_load) begin
         time_next = {time_hi, pending_lo};
      end else begin
         time_next = vita_time_o + 64'd1;
      end
   end

   always_ff @(posedge dsp_clk or negedge arst_n_i) begin
      if (!arst_n_i) begin
         vita_time_o     <= '0;
         vita_time_pps_o <= '0;
         good_sync_o     <= 1'b0;
      end else begin
         vita_time_o <= time_next;
         // Latch the time this edge starts
         if (pps_edge) begin
            vita_time_pps_o <= time_next;
         end
         if (pps_load) begin
            good_sync_o <= 1'b1;
         end
      end
   end

endmodule

// File: design/status_readback.sv
// Status readback mux
`timescale 1ns/1ps

module status_readback (
   input  logic                               dsp_clk,
   input  logic                               arst_n_i,
   input  u2_ctrl_pkg::rb_addr_t              rb_addr_i,
   input  logic [u2_ctrl_pkg::GPIO_WIDTH-1:0] gpio_i,
   input  u2_ctrl_pkg::vita_time_t            vita_time_i,
   input  u2_ctrl_pkg::vita_time_t            vita_time_pps_i,
   input  logic                               clk_status_i,
   input  logic                               serdes_link_up_i,
   output logic [31:0]                        rb_data_o
);

   import u2_ctrl_pkg::*;

   set_data_t rb_word;
   set_data_t status_word;

   // Clock status at bit 11, link up at bit 10
   assign status_word = {20'd0, clk_status_i, serdes_link_up_i, 10'd0};

   always_comb begin
      case (rb_addr_i)
         RB_GPIO:    rb_word = gpio_i;
         RB_TIME_HI: rb_word = vita_time_i[63:32];
         RB_TIME_LO: rb_word = vita_time_i[31:0];
         RB_COMPAT:  rb_word = COMPAT_NUM;
         RB_STATUS:  rb_word = status_word;
         RB_PPS_HI:  rb_word = vita_time_pps_i[63:32];
         RB_PPS_LO:  rb_word = vita_time_pps_i[31:0];
         // Words 0 to 8 belong to dropped blocks
         default:    rb_word = '0;
      endcase
   end

   // One cycle from address to data, a new address every cycle
   always_ff @(posedge dsp_clk or negedge arst_n_i) begin
      if (!arst_n_i) begin
         rb_data_o <= '0;
      end else begin
         rb_data_o <= rb_word;
      end
   end

endmodule

// File: design/u2_ctrl_core.sv
// DSP clock control core
`timescale 1ns/1ps

module u2_ctrl_core (
   input  logic                               dsp_clk,
   input  logic                               arst_n_i,
   // Settings bus
   input  logic                               set_stb_i,
   input  u2_ctrl_pkg::set_addr_t             set_addr_i,
   input  u2_ctrl_pkg::set_data_t             set_data_i,
   // Run flags and status
   input  logic                               run_rx0_i,
   input  logic                               run_rx1_i,
   input  logic                               run_tx_i,
   input  logic                               pps_i,
   input  logic                               clk_status_i,
   input  logic                               serdes_link_up_i,
   input  logic [u2_ctrl_pkg::GPIO_WIDTH-1:0] gpio_i,
   input  u2_ctrl_pkg::rb_addr_t              rb_addr_i,
   // Clock generator
   output logic                               clock_ready_o,
   output logic [1:0]                         clk_en_o,
   output logic [1:0]                         clk_sel_o,
   // SERDES control
   output logic                               ser_enable_o,
   output logic                               ser_prbsen_o,
   output logic                               ser_loopen_o,
   output logic                               ser_rx_en_o,
   // ADC control
   output logic                               adc_oe_a_o,
   output logic                               adc_on_a_o,
   output logic                               adc_oe_b_o,
   output logic                               adc_on_b_o,
   output logic                               phy_resetn_o,
   output logic [7:0]                         leds_o,
   output logic [u2_ctrl_pkg::GPIO_WIDTH-1:0] gpio_o,
   output logic [u2_ctrl_pkg::GPIO_WIDTH-1:0] gpio_oe_o,
   output logic [31:0]                        rb_data_o
);

   import u2_ctrl_pkg::*;

   led_t       clock_ctrl;
   led_t       serdes_ctrl;
   led_t       adc_ctrl;
   logic       phy_reset;
   logic       rx_active;
   vita_time_t vita_time;
   vita_time_t vita_time_pps;
   logic       good_sync;

   //////////////////////////////////////////////////
   // Misc control registers

   setting_reg #(.payload_t(led_t), .MY_ADDR(SR_CLK_CTRL), .AT_RESET(8'h00)) sr_clk (
      .dsp_clk (dsp_clk), .arst_n_i (arst_n_i), .set_stb_i (set_stb_i),
      .set_addr_i (set_addr_i), .set_data_i (set_data_i), .value_o (clock_ctrl)
   );

   setting_reg #(.payload_t(led_t), .MY_ADDR(SR_SER_CTRL), .AT_RESET(8'h00)) sr_ser (
      .dsp_clk (dsp_clk), .arst_n_i (arst_n_i), .set_stb_i (set_stb_i),
      .set_addr_i (set_addr_i), .set_data_i (set_data_i), .value_o (serdes_ctrl)
   );

   setting_reg #(.payload_t(led_t), .MY_ADDR(SR_ADC_CTRL), .AT_RESET(8'h00)) sr_adc (
      .dsp_clk (dsp_clk), .arst_n_i (arst_n_i), .set_stb_i (set_stb_i),
      .set_addr_i (set_addr_i), .set_data_i (set_data_i), .value_o (adc_ctrl)
   );

   setting_reg #(.payload_t(logic), .MY_ADDR(SR_PHY_RST), .AT_RESET(1'b0)) sr_phy (
      .dsp_clk (dsp_clk), .arst_n_i (arst_n_i), .set_stb_i (set_stb_i),
      .set_addr_i (set_addr_i), .set_data_i (set_data_i), .value_o (phy_reset)
   );

   assign {clock_ready_o, clk_en_o, clk_sel_o} = clock_ctrl[4:0];
   assign {ser_enable_o, ser_prbsen_o, ser_loopen_o, ser_rx_en_o} = serdes_ctrl[3:0];
   assign {adc_oe_a_o, adc_on_a_o, adc_oe_b_o, adc_on_b_o} = adc_ctrl[3:0];
   assign phy_resetn_o = ~phy_reset;

   // Either receive chain running
   always_ff @(posedge dsp_clk or negedge arst_n_i) begin
      if (!arst_n_i) begin
         rx_active <= 1'b0;
      end else begin
         rx_active <= run_rx0_i | run_rx1_i;
      end
   end

   //////////////////////////////////////////////////
   // Status, GPIO and time blocks

   led_select led_select0 (
      .dsp_clk (dsp_clk), .arst_n_i (arst_n_i), .set_stb_i (set_stb_i),
      .set_addr_i (set_addr_i), .set_data_i (set_data_i),
      .rx_active_i (rx_active), .run_tx_i (run_tx_i), .clk_status_i (clk_status_i),
      .serdes_link_up_i (serdes_link_up_i), .good_sync_i (good_sync), .leds_o (leds_o)
   );

   gpio_atr gpio_atr0 (
      .dsp_clk (dsp_clk), .arst_n_i (arst_n_i), .set_stb_i (set_stb_i),
      .set_addr_i (set_addr_i), .set_data_i (set_data_i),
      .rx_active_i (rx_active), .run_tx_i (run_tx_i),
      .gpio_o (gpio_o), .gpio_oe_o (gpio_oe_o)
   );

   vita_time vita_time0 (
      .dsp_clk (dsp_clk), .arst_n_i (arst_n_i), .set_stb_i (set_stb_i),
      .set_addr_i (set_addr_i), .set_data_i (set_data_i), .pps_i (pps_i),
      .vita_time_o (vita_time), .vita_time_pps_o (vita_time_pps), .good_sync_o (good_sync)
   );

   status_readback status_readback0 (
      .dsp_clk (dsp_clk), .arst_n_i (arst_n_i), .rb_addr_i (rb_addr_i), .gpio_i (gpio_i),
      .vita_time_i (vita_time), .vita_time_pps_i (vita_time_pps),
      .clk_status_i (clk_status_i), .serdes_link_up_i (serdes_link_up_i),
      .rb_data_o (rb_data_o)
   );

endmodule

// File: tests/u2_ctrl_core_sva.sv
// Control core assertions
`timescale 1ns/1ps

module u2_ctrl_core_sva #(
   parameter bit CHECK_TIME = 1'b0,
   parameter bit CHECK_RB   = 1'b0
) (
   input logic        dsp_clk,
   input logic        arst_n_i,
   input logic [63:0] vita_time,
   input logic        imm_load,
   input logic        pps_load,
   input logic        good_sync,
   input logic [3:0]  rb_addr,
   input logic [31:0] rb_gpio,
   input logic [31:0] rb_data
);

   import u2_ctrl_pkg::*;

   generate
      if (CHECK_TIME) begin : g_time
         // Free-running tick when no load fires
         a_tick: assert property (@(posedge dsp_clk) disable iff (!arst_n_i)
            $past(arst_n_i) && !$past(imm_load) && !$past(pps_load)
               |-> vita_time == $past(vita_time) + 64'd1)
            else $error("time counter did not advance by one");

         // Sync flag starts low out of reset
         a_sync_rst: assert property (@(posedge dsp_clk) disable iff (!arst_n_i)
            !$past(arst_n_i) |-> !good_sync)
            else $error("good_sync high right after reset");
      end

      if (CHECK_RB) begin : g_rb
         // Zero words and the GPIO word land one cycle after their address
         a_rb_lat: assert property (@(posedge dsp_clk) disable iff (!arst_n_i)
            $past(arst_n_i) && ($past(rb_addr) <= RB_GPIO)
               |-> rb_data == (($past(rb_addr) == RB_GPIO) ? $past(rb_gpio) : 32'd0))
            else $error("readback data does not follow its address by one cycle");
      end
   endgenerate

endmodule

bind vita_time u2_ctrl_core_sva #(.CHECK_TIME(1'b1)) time_sva (
   .dsp_clk (dsp_clk), .arst_n_i (arst_n_i), .vita_time (vita_time_o),
   .imm_load (imm_load), .pps_load (pps_load), .good_sync (good_sync_o),
   .rb_addr (4'd0), .rb_gpio (32'd0), .rb_data (32'd0)
);

bind status_readback u2_ctrl_core_sva #(.CHECK_RB(1'b1)) rb_sva (
   .dsp_clk (dsp_clk), .arst_n_i (arst_n_i), .vita_time (64'd0),
   .imm_load (1'b0), .pps_load (1'b0), .good_sync (1'b0),
   .rb_addr (rb_addr_i), .rb_gpio (gpio_i), .rb_data (rb_data_o)
);

// File: tests/u2_ctrl_core_tb.sv
// Control core testbench
`timescale 1ns/1ps

module u2_ctrl_core_tb;

   import u2_ctrl_pkg::*;

   localparam int N_MISC = 40;
   localparam int N_LED  = 30;
   localparam int N_GPIO = 30;
   localparam int N_RB   = 60;
   // Generous bound on cycles used by all tests
   localparam int RUN_CYCLES = N_MISC * 4 + N_LED * 8 + N_GPIO * 16 + N_RB * 3 + 300;

   logic        dsp_clk = 1'b0;
   logic        arst_n_i;
   logic        set_stb_i;
   set_addr_t   set_addr_i;
   set_data_t   set_data_i;
   logic        run_rx0_i, run_rx1_i, run_tx_i, pps_i;
   logic        clk_status_i, serdes_link_up_i;
   logic [31:0] gpio_i;
   rb_addr_t    rb_addr_i;
   logic        clock_ready_o, ser_enable_o, ser_prbsen_o, ser_loopen_o, ser_rx_en_o;
   logic [1:0]  clk_en_o, clk_sel_o;
   logic        adc_oe_a_o, adc_on_a_o, adc_oe_b_o, adc_on_b_o, phy_resetn_o;
   logic [7:0]  leds_o;
   logic [31:0] gpio_o, gpio_oe_o, rb_data_o;

   integer seed = 32'hc2ae3df3;
   integer errors = 0;
   integer checks = 0;
   longint cyc = 0;

   // Reference model state
   logic [7:0]  m_clk = 0, m_ser = 0, m_adc = 0, m_sw = 0, m_src = 8'b0001_1110;
   logic        m_phy = 0, m_sync = 0;
   logic [31:0] m_gpio [5] = '{default: 32'd0};
   logic [31:0] m_hi = 0;
   logic [63:0] m_base = 0, m_pps = 0;
   longint      m_t0 = 0;

   u2_ctrl_core dut0 (.*);

   always #10 dsp_clk = ~dsp_clk;

   always @(posedge dsp_clk) cyc <= cyc + 1;

   initial begin
      #(RUN_CYCLES * 20 * 2);
      $display("Watchdog expired before the tests finished");
      $display("Simulation failed");
      $finish;
   end

   task automatic check_val(input logic [63:0] got, input logic [63:0] exp, input string what);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("FAIL at %0t ns: %s is %h, expected %h", $time, what, got, exp);
      end
   endtask

   task automatic model_write(input set_addr_t a, input set_data_t d);
      case (a)
         8'd0:   m_clk = d[7:0];
         8'd1:   m_ser = d[7:0];
         8'd2:   m_adc = d[7:0];
         8'd3:   m_sw  = d[7:0];
         8'd4:   m_phy = d[0];
         8'd6:   m_src = d[7:0];
         8'd10:  m_hi  = d;
         8'd184, 8'd185, 8'd186, 8'd187, 8'd188: m_gpio[a - 8'd184] = d;
         default: ;
      endcase
   endtask

   // Single strobe that returns just after its capturing edge
   task automatic write_reg(input set_addr_t a, input set_data_t d);
      @(posedge dsp_clk);
      set_stb_i  <= 1'b1;
      set_addr_i <= a;
      set_data_i <= d;
      @(posedge dsp_clk);
      set_stb_i  <= 1'b0;
      model_write(a, d);
   endtask

   function automatic logic [7:0] exp_leds();
      logic [7:0] hw;
      hw = {3'b000, run_tx_i, run_rx0_i | run_rx1_i, clk_status_i,
            serdes_link_up_i & m_sync, 1'b0};
      return (m_src & hw) | (~m_src & m_sw);
   endfunction

   task automatic check_ctrl();
      check_val({clock_ready_o, clk_en_o, clk_sel_o}, m_clk[4:0], "clock control");
      check_val({ser_enable_o, ser_prbsen_o, ser_loopen_o, ser_rx_en_o}, m_ser[3:0], "serdes");
      check_val({adc_oe_a_o, adc_on_a_o, adc_oe_b_o, adc_on_b_o}, m_adc[3:0], "adc");
      check_val(phy_resetn_o, !m_phy, "phy_resetn_o");
   endtask

   function automatic logic [31:0] rb_expect(input rb_addr_t a, input longint t);
      logic [63:0] now;
      now = m_base + 64'(t - m_t0);
      case (a)
         4'd9:    return gpio_i;
         4'd10:   return now[63:32];
         4'd11:   return now[31:0];
         4'd12:   return {16'd8, 16'd3};
         4'd13:   return {20'd0, clk_status_i, serdes_link_up_i, 10'd0};
         4'd14:   return m_pps[63:32];
         4'd15:   return m_pps[31:0];
         default: return 32'd0;
      endcase
   endfunction

   task automatic read_word(input rb_addr_t a);
      longint t;
      @(posedge dsp_clk);
      rb_addr_i <= a;
      @(negedge dsp_clk);
      t = cyc;
      @(posedge dsp_clk);
      @(negedge dsp_clk);
      check_val(rb_data_o, rb_expect(a, t), $sformatf("readback word %0d", a));
   endtask

   initial begin
      logic [7:0]  a;
      logic [31:0] hi, lo;
      arst_n_i = 0;
      set_stb_i = 0;
      set_addr_i = 0;
      set_data_i = 0;
      {run_rx0_i, run_rx1_i, run_tx_i, pps_i, serdes_link_up_i} = '0;
      clk_status_i = 1;
      gpio_i = 0;
      rb_addr_i = 0;
      repeat (2) @(posedge dsp_clk);
      arst_n_i <= 1'b1;

      // Reset state
      @(negedge dsp_clk);
      check_ctrl();
      check_val({gpio_o, gpio_oe_o}, 64'd0, "gpio after reset");
      check_val(leds_o, exp_leds() & 8'b0001_1110, "leds after reset");

      // Misc and unmapped writes
      for (int i = 0; i < N_MISC; i++) begin
         a = ($random(seed) & 1) ? 8'($random(seed) & 7) : 8'(20 + ($random(seed) & 63));
         write_reg(a, $random(seed));
         @(negedge dsp_clk);
         check_ctrl();
      end

      // LED selection
      for (int i = 0; i < N_LED; i++) begin
         write_reg(SR_LED_SW, $random(seed));
         write_reg(SR_LED_SRC, $random(seed));
         @(posedge dsp_clk);
         {run_rx0_i, run_rx1_i, run_tx_i, clk_status_i, serdes_link_up_i} <= 5'($random(seed));
         repeat (2) @(posedge dsp_clk);
         @(negedge dsp_clk);
         check_val(leds_o, exp_leds(), "leds_o");
      end

      ////////////////////////////////////////////////
      // GPIO ATR

      for (int i = 0; i < N_GPIO; i++) begin
         for (int r = 0; r < 5; r++) begin
            write_reg(SR_GPIO + 8'(r), $random(seed));
         end
         @(posedge dsp_clk);
         {run_rx0_i, run_rx1_i, run_tx_i} <= 3'($random(seed));
         repeat (2) @(posedge dsp_clk);
         @(negedge dsp_clk);
         case ({run_rx0_i | run_rx1_i, run_tx_i})
            2'b00:   check_val(gpio_o, m_gpio[0], "gpio_o idle");
            2'b10:   check_val(gpio_o, m_gpio[1], "gpio_o rx");
            2'b01:   check_val(gpio_o, m_gpio[2], "gpio_o tx");
            default: check_val(gpio_o, m_gpio[3], "gpio_o full duplex");
         endcase
         check_val(gpio_oe_o, m_gpio[4], "gpio_oe_o");
      end

      ////////////////////////////////////////////////
      // Time loads

      hi = $random(seed);
      lo = $random(seed);
      write_reg(SR_TIME_MODE, 32'd1);
      write_reg(SR_TIME_HI, hi);
      write_reg(SR_TIME_LO, lo);
      @(negedge dsp_clk);
      m_t0 = cyc;
      m_base = {m_hi, lo};
      repeat ($random(seed) & 15) @(posedge dsp_clk);
      read_word(RB_TIME_HI);
      read_word(RB_TIME_LO);

      // Armed load with sync seen on LED 1
      @(posedge dsp_clk);
      serdes_link_up_i <= 1'b1;
      write_reg(SR_LED_SRC, 32'(m_src | 8'h02));
      hi = $random(seed);
      lo = $random(seed);
      write_reg(SR_TIME_MODE, 32'd0);
      write_reg(SR_TIME_HI, hi);
      write_reg(SR_TIME_LO, lo);
      repeat (4) @(posedge dsp_clk);
      @(negedge dsp_clk);
      check_val(leds_o, exp_leds(), "leds_o before pps");
      @(posedge dsp_clk);
      pps_i <= 1'b1;
      // Two sync stages plus the edge register
      repeat (3) @(posedge dsp_clk);
      @(negedge dsp_clk);
      m_t0 = cyc;
      m_base = {m_hi, lo};
      m_pps = m_base;
      m_sync = 1'b1;
      check_val(leds_o, exp_leds(), "leds_o after pps");
      @(posedge dsp_clk);
      pps_i <= 1'b0;
      read_word(RB_TIME_HI);
      read_word(RB_TIME_LO);
      read_word(RB_PPS_HI);
      read_word(RB_PPS_LO);

      // Random readback
      for (int i = 0; i < N_RB; i++) begin
         @(posedge dsp_clk);
         gpio_i <= $random(seed);
         {clk_status_i, serdes_link_up_i} <= 2'($random(seed));
         read_word(4'($random(seed)));
      end

      $display("Checks: %0d, errors: %0d", checks, errors);
      if (errors == 0) begin
         $display("Simulation passed");
      end else begin
         $display("Simulation failed");
      end
      $finish;
   end

endmodule

// File: u2_ctrl_core.f
design/u2_ctrl_pkg.sv
design/setting_reg.sv
design/led_select.sv
design/gpio_atr.sv
design/vita_time.sv
design/status_readback.sv
design/u2_ctrl_core.sv
tests/u2_ctrl_core_sva.sv
tests/u2_ctrl_core_tb.sv
